// File: dma_pkg.sv
/*
 * Shared widths, DMA opcodes and bus types of the DMA instruction frontend.
 * Every design file refers to these by scoped name.
 */

package dma_pkg;

    localparam int unsigned ADDR_W   = 48;
    localparam int unsigned DATA_W   = 64;
    localparam int unsigned TF_ID_W  = 32;
    localparam int unsigned REP_W    = 32;
    localparam int unsigned ACC_ID_W = 5;

    // major opcode of the DMA extension (custom-1)
    localparam logic [6:0] OPC_DMA = 7'b0101011;

    // ------------------------------
    // function field values
    // ------------------------------
    localparam logic [6:0] DMSRC   = 7'b0000000;
    localparam logic [6:0] DMDST   = 7'b0000001;
    localparam logic [6:0] DMCPYI  = 7'b0000010;
    localparam logic [6:0] DMCPY   = 7'b0000011;
    localparam logic [6:0] DMSTATI = 7'b0000100;
    localparam logic [6:0] DMSTAT  = 7'b0000101;
    localparam logic [6:0] DMSTR   = 7'b0000110;
    localparam logic [6:0] DMREP   = 7'b0000111;

    // instruction word as seen by the decoder
    typedef struct packed {
        logic [6:0]  funct7;
        logic [17:0] operands;
        logic [6:0]  opcode;
    } op_enc_t;

    // immediate forms carry config in the rs2 field
    typedef struct packed {
        logic [6:0]  funct7;
        logic [2:0]  chan;
        logic [1:0]  cfg;
        logic [19:0] regs;
    } op_imm_t;

    typedef union packed {
        op_enc_t enc;
        op_imm_t imm;
    } op_word_u;

    typedef struct packed {
        logic [ACC_ID_W-1:0] tag;
        op_word_u            op;
        logic [DATA_W-1:0]   arga;
        logic [DATA_W-1:0]   argb;
    } acc_req_t;

    typedef struct packed {
        logic [ACC_ID_W-1:0] tag;
        logic [DATA_W-1:0]   data;
        logic                error;
    } acc_rsp_t;

    typedef struct packed {
        logic [ADDR_W-1:0] src_addr;
        logic [ADDR_W-1:0] dst_addr;
        logic [ADDR_W-1:0] length;
        logic [REP_W-1:0]  src_stride;
        logic [REP_W-1:0]  dst_stride;
        logic [REP_W-1:0]  reps;
    } nd_job_t;

    typedef struct packed {
        logic [ADDR_W-1:0] src_addr;
        logic [ADDR_W-1:0] dst_addr;
        logic [ADDR_W-1:0] length;
    } burst_req_t;

endpackage

// File: dma_tf_id_counter.sv
/*
 * Issued and completed transfer-ID counters, both wrap at TF_ID_W bits.
 */
`timescale 1ns/1ps

module dma_tf_id_counter (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        issue_i,
    input  logic                        retire_i,
    output logic [dma_pkg::TF_ID_W-1:0] next_id_o,
    output logic [dma_pkg::TF_ID_W-1:0] completed_id_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            next_id_o      <= '0;
            completed_id_o <= '0;
        end else begin
            if (issue_i) begin
                next_id_o <= next_id_o + 1'b1;
            end
            if (retire_i) begin
                completed_id_o <= completed_id_o + 1'b1;
            end
        end
    end

endmodule

// File: dma_rsp_spill.sv
/*
 * Two-entry spill register on the response path. The output slot drives the
 * port directly from flops, the skid slot catches one response while the
 * output is stalled. Ready drops only when both slots hold data.
 */
`timescale 1ns/1ps

module dma_rsp_spill (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  dma_pkg::acc_rsp_t data_i,
    input  logic              valid_i,
    output logic              ready_o,
    output dma_pkg::acc_rsp_t data_o,
    output logic              valid_o,
    input  logic              ready_i
);

    dma_pkg::acc_rsp_t out_data_q;
    dma_pkg::acc_rsp_t skid_data_q;
    logic              out_valid_q;
    logic              skid_valid_q;
    logic              push;
    logic              pop;

    assign ready_o = !skid_valid_q;
    assign valid_o = out_valid_q;
    assign data_o  = out_data_q;
    assign push    = valid_i & ready_o;
    assign pop     = out_valid_q & ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else begin
            out_valid_q  <= (out_valid_q & ~pop) | push | skid_valid_q;
            skid_valid_q <= (skid_valid_q & ~pop) | (push & out_valid_q & ~pop);
        end
    end

    // skid entry is older, so it moves up first
    always_ff @(posedge clk_i) begin
        if (pop && skid_valid_q) begin
            out_data_q <= skid_data_q;
        end else if (push && (!out_valid_q || pop)) begin
            out_data_q <= data_i;
        end
        if (push && out_valid_q && !pop) begin
            skid_data_q <= data_i;
        end
    end

endmodule

// File: dma_req_fifo.sv
/*
 * Circular-buffer queue of launched copy jobs with valid/ready on both sides.
 * Ready while not full, a pushed job shows at the output one cycle later.
 */
`timescale 1ns/1ps

module dma_req_fifo #(
    parameter int unsigned DEPTH = 3
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  dma_pkg::nd_job_t data_i,
    input  logic             valid_i,
    output logic             ready_o,
    output dma_pkg::nd_job_t data_o,
    output logic             valid_o,
    input  logic             ready_i,
    output logic             empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    dma_pkg::nd_job_t mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             push;
    logic             pop;

    assign ready_o = (cnt_q != CNT_W'(DEPTH));
    assign valid_o = (cnt_q != '0);
    assign empty_o = (cnt_q == '0);
    assign data_o  = mem_q[rd_ptr_q];
    assign push    = valid_i & ready_o;
    assign pop     = valid_o & ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop && !push) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

// File: dma_twod_splitter.sv
/*
 * Splits one queued job into reps one-dimensional bursts, advancing source
 * and destination by their strides. Counts burst completions and pulses
 * job_done_o once all of them are back.
 */
`timescale 1ns/1ps

module dma_twod_splitter (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  dma_pkg::nd_job_t    job_i,
    input  logic                job_valid_i,
    output logic                job_ready_o,
    output dma_pkg::burst_req_t burst_o,
    output logic                burst_valid_o,
    input  logic                burst_ready_i,
    input  logic                burst_done_i,
    output logic                job_done_o,
    output logic                busy_o
);

    dma_pkg::nd_job_t          cur_q;
    logic                      busy_q;
    logic                      done_q;
    logic [dma_pkg::REP_W-1:0] issued_q;
    logic [dma_pkg::REP_W-1:0] retired_q;
    logic                      job_hs;
    logic                      burst_hs;
    logic                      last_done;

    // only takes a new job when idle
    assign job_ready_o   = !busy_q;
    assign job_hs        = job_valid_i & !busy_q;
    assign burst_valid_o = busy_q && (issued_q != cur_q.reps);
    assign burst_hs      = burst_valid_o & burst_ready_i;
    assign last_done     = busy_q && burst_done_i && !done_q &&
                           (retired_q + dma_pkg::REP_W'(1) == cur_q.reps);

    assign burst_o.src_addr = cur_q.src_addr;
    assign burst_o.dst_addr = cur_q.dst_addr;
    assign burst_o.length   = cur_q.length;
    assign job_done_o       = done_q;
    assign busy_o           = busy_q;

    // ------------------------------
    // issue and completion counters
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            issued_q  <= '0;
            retired_q <= '0;
        end else begin
            done_q <= last_done;
            if (job_hs) begin
                busy_q    <= 1'b1;
                issued_q  <= '0;
                retired_q <= '0;
            end else begin
                // stays busy through the done pulse
                if (done_q) begin
                    busy_q <= 1'b0;
                end
                if (burst_hs) begin
                    issued_q <= issued_q + 1'b1;
                end
                if (busy_q && burst_done_i) begin
                    retired_q <= retired_q + 1'b1;
                end
            end
        end
    end

    // running addresses step by stride per issued burst
    always_ff @(posedge clk_i) begin
        if (job_hs) begin
            cur_q <= job_i;
        end else if (burst_hs) begin
            cur_q.src_addr <= cur_q.src_addr + dma_pkg::ADDR_W'(cur_q.src_stride);
            cur_q.dst_addr <= cur_q.dst_addr + dma_pkg::ADDR_W'(cur_q.dst_stride);
        end
    end

endmodule

// File: dma_inst_decoder.sv
/*
 * Decodes offloaded DMA instructions. Register writes update the staged job,
 * copies push the job into the queue and answer with the transfer ID,
 * status reads answer with the selected counter or flag.
 */
`timescale 1ns/1ps

module dma_inst_decoder (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  dma_pkg::acc_req_t              acc_req_i,
    input  logic                           acc_req_valid_i,
    output logic                           acc_req_ready_o,
    output dma_pkg::nd_job_t               job_o,
    output logic                           job_valid_o,
    input  logic                           job_ready_i,
    output dma_pkg::acc_rsp_t              rsp_o,
    output logic                           rsp_valid_o,
    input  logic                           rsp_ready_i,
    input  logic [dma_pkg::TF_ID_W-1:0]    next_id_i,
    input  logic [dma_pkg::TF_ID_W-1:0]    completed_id_i,
    input  logic                           busy_i
);

    localparam int unsigned HI_W = dma_pkg::ADDR_W - 32;

    dma_pkg::nd_job_t job_q;
    dma_pkg::nd_job_t job_d;
    // bit 1 is the 2D flag for copies, both bits select the status item
    logic [1:0]       cfg;
    logic [6:0]       funct;

    assign funct = acc_req_i.op.enc.funct7;

    // ------------------------------
    // instruction decode
    // ------------------------------
    always_comb begin : proc_decode
        job_d           = job_q;
        cfg             = 2'b00;
        acc_req_ready_o = 1'b0;
        job_valid_o     = 1'b0;
        rsp_valid_o     = 1'b0;
        rsp_o           = '0;
        rsp_o.tag       = acc_req_i.tag;

        if (acc_req_valid_i && acc_req_i.op.enc.opcode == dma_pkg::OPC_DMA) begin
            case (funct)
                dma_pkg::DMSRC: begin
                    job_d.src_addr  = {acc_req_i.argb[HI_W-1:0], acc_req_i.arga[31:0]};
                    acc_req_ready_o = 1'b1;
                end
                dma_pkg::DMDST: begin
                    job_d.dst_addr  = {acc_req_i.argb[HI_W-1:0], acc_req_i.arga[31:0]};
                    acc_req_ready_o = 1'b1;
                end
                dma_pkg::DMSTR: begin
                    job_d.src_stride = acc_req_i.arga[dma_pkg::REP_W-1:0];
                    job_d.dst_stride = acc_req_i.argb[dma_pkg::REP_W-1:0];
                    acc_req_ready_o  = 1'b1;
                end
                dma_pkg::DMREP: begin
                    job_d.reps      = acc_req_i.arga[dma_pkg::REP_W-1:0];
                    acc_req_ready_o = 1'b1;
                end
                dma_pkg::DMCPYI, dma_pkg::DMCPY: begin
                    cfg = (funct == dma_pkg::DMCPYI) ? acc_req_i.op.imm.cfg
                                                     : acc_req_i.argb[1:0];
                    job_d.length = acc_req_i.arga[dma_pkg::ADDR_W-1:0];
                    rsp_o.data   = dma_pkg::DATA_W'(next_id_i);
                    // job, response and request all handshake together
                    if (rsp_ready_i) begin
                        job_valid_o = 1'b1;
                        if (job_ready_i) begin
                            rsp_valid_o     = 1'b1;
                            acc_req_ready_o = 1'b1;
                        end
                    end
                end
                dma_pkg::DMSTATI, dma_pkg::DMSTAT: begin
                    cfg = (funct == dma_pkg::DMSTATI) ? acc_req_i.op.imm.cfg
                                                      : acc_req_i.argb[1:0];
                    case (cfg)
                        2'd0:    rsp_o.data = dma_pkg::DATA_W'(completed_id_i);
                        2'd1:    rsp_o.data = dma_pkg::DATA_W'(next_id_i);
                        2'd2:    rsp_o.data = dma_pkg::DATA_W'(busy_i);
                        default: rsp_o.data = dma_pkg::DATA_W'(!job_ready_i);
                    endcase
                    if (rsp_ready_i) begin
                        rsp_valid_o     = 1'b1;
                        acc_req_ready_o = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // 1D jobs and empty 2D jobs run one repetition
    always_comb begin : proc_job_out
        job_o = job_d;
        if (!cfg[1] || job_d.reps == '0) begin
            job_o.reps = dma_pkg::REP_W'(1);
        end
    end

    // staged job registers
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            job_q <= '0;
        end else if (acc_req_valid_i && acc_req_ready_o) begin
            job_q <= job_d;
        end
    end

endmodule

// File: dma_inst_frontend.sv
/*
 * Top level of the DMA instruction frontend. Takes offloaded instructions,
 * queues copy jobs, emits one-dimensional bursts and returns responses
 * through the spill register. REQ_FIFO_DEPTH sets the job queue depth.
 */
`timescale 1ns/1ps

module dma_inst_frontend #(
    parameter int unsigned REQ_FIFO_DEPTH = 3
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  dma_pkg::acc_req_t   acc_req_i,
    input  logic                acc_req_valid_i,
    output logic                acc_req_ready_o,
    output dma_pkg::acc_rsp_t   acc_rsp_o,
    output logic                acc_rsp_valid_o,
    input  logic                acc_rsp_ready_i,
    output dma_pkg::burst_req_t burst_req_o,
    output logic                burst_valid_o,
    input  logic                burst_ready_i,
    input  logic                burst_done_i,
    output logic                busy_o
);

    dma_pkg::nd_job_t            dec_job;
    logic                        dec_job_valid;
    logic                        dec_job_ready;
    dma_pkg::nd_job_t            fifo_job;
    logic                        fifo_job_valid;
    logic                        fifo_job_ready;
    logic                        fifo_empty;
    dma_pkg::acc_rsp_t           dec_rsp;
    logic                        dec_rsp_valid;
    logic                        dec_rsp_ready;
    logic                        job_done;
    logic                        splitter_busy;
    logic [dma_pkg::TF_ID_W-1:0] next_id;
    logic [dma_pkg::TF_ID_W-1:0] completed_id;

    assign busy_o = splitter_busy;

    // ------------------------------
    // decode and response path
    // ------------------------------
    dma_inst_decoder u_decoder (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .acc_req_i       (acc_req_i),
        .acc_req_valid_i (acc_req_valid_i),
        .acc_req_ready_o (acc_req_ready_o),
        .job_o           (dec_job),
        .job_valid_o     (dec_job_valid),
        .job_ready_i     (dec_job_ready),
        .rsp_o           (dec_rsp),
        .rsp_valid_o     (dec_rsp_valid),
        .rsp_ready_i     (dec_rsp_ready),
        .next_id_i       (next_id),
        .completed_id_i  (completed_id),
        .busy_i          (splitter_busy | ~fifo_empty)
    );

    dma_rsp_spill u_rsp_spill (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .data_i  (dec_rsp),
        .valid_i (dec_rsp_valid),
        .ready_o (dec_rsp_ready),
        .data_o  (acc_rsp_o),
        .valid_o (acc_rsp_valid_o),
        .ready_i (acc_rsp_ready_i)
    );

    // IDs are issued when a job enters the queue
    dma_tf_id_counter u_id_counter (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .issue_i        (dec_job_valid & dec_job_ready),
        .retire_i       (job_done),
        .next_id_o      (next_id),
        .completed_id_o (completed_id)
    );

    // ------------------------------
    // job queue and splitter
    // ------------------------------
    dma_req_fifo #(
        .DEPTH (REQ_FIFO_DEPTH)
    ) u_req_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .data_i  (dec_job),
        .valid_i (dec_job_valid),
        .ready_o (dec_job_ready),
        .data_o  (fifo_job),
        .valid_o (fifo_job_valid),
        .ready_i (fifo_job_ready),
        .empty_o (fifo_empty)
    );

    dma_twod_splitter u_splitter (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .job_i         (fifo_job),
        .job_valid_i   (fifo_job_valid),
        .job_ready_o   (fifo_job_ready),
        .burst_o       (burst_req_o),
        .burst_valid_o (burst_valid_o),
        .burst_ready_i (burst_ready_i),
        .burst_done_i  (burst_done_i),
        .job_done_o    (job_done),
        .busy_o        (splitter_busy)
    );

endmodule

// File: dma_inst_frontend_assert.sv
/*
 * Handshake and reset checks on the DMA instruction frontend, bound into
 * the top level. fail_cnt counts failed assertions for the testbench.
 */
`timescale 1ns/1ps

module dma_inst_frontend_assert (
    input logic                clk_i,
    input logic                rst_n_i,
    input dma_pkg::burst_req_t burst_req_i,
    input logic                burst_valid_i,
    input logic                burst_ready_i,
    input dma_pkg::acc_rsp_t   rsp_i,
    input logic                rsp_valid_i,
    input logic                rsp_ready_i,
    input logic                job_done_i,
    input logic                splitter_busy_i,
    input logic                busy_i
);

    int unsigned fail_cnt = 0;

    // stalled burst keeps its addresses and length
    a_burst_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        burst_valid_i && !burst_ready_i |=> burst_valid_i && $stable(burst_req_i))
        else begin
            $error("burst request dropped or changed while stalled");
            fail_cnt++;
        end

    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
        else begin
            $error("response dropped or changed while stalled");
            fail_cnt++;
        end

    // ------------------------------
    // reset and splitter state
    // ------------------------------
    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_n_i |=> !burst_valid_i && !rsp_valid_i && !busy_i)
        else begin
            $error("valid or busy output high during reset");
            fail_cnt++;
        end

    a_done_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        job_done_i |-> splitter_busy_i)
        else begin
            $error("job done pulse while the splitter is idle");
            fail_cnt++;
        end

endmodule

bind dma_inst_frontend dma_inst_frontend_assert u_assert (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .burst_req_i     (burst_req_o),
    .burst_valid_i   (burst_valid_o),
    .burst_ready_i   (burst_ready_i),
    .rsp_i           (acc_rsp_o),
    .rsp_valid_i     (acc_rsp_valid_o),
    .rsp_ready_i     (acc_rsp_ready_i),
    .job_done_i      (job_done),
    .splitter_busy_i (splitter_busy),
    .busy_i          (busy_o)
);

// File: tb_dma_inst_frontend.sv
/*
 * Testbench for the DMA instruction frontend. Replays dma_stim.txt,
 * models the burst backend with random ready and delayed completions,
 * and checks every response and burst in order.
 */
`timescale 1ns/1ps

module tb_dma_inst_frontend;

    localparam int unsigned FIFO_DEPTH  = 3;
    localparam int unsigned HOLD_CYCLES = 8;

    // one stim line, ctl bits are drain, burst hold, response hold, expect stall
    typedef struct packed {
        logic [3:0]  ctl;
        logic [4:0]  tag;
        logic [6:0]  funct;
        logic [1:0]  cfg;
        logic [63:0] arga;
        logic [63:0] argb;
        logic [63:0] rsp_data;
    } stim_t;

    logic                clk_i;
    logic                rst_n_i;
    dma_pkg::acc_req_t   acc_req_i;
    logic                acc_req_valid_i;
    logic                acc_req_ready_o;
    dma_pkg::acc_rsp_t   acc_rsp_o;
    logic                acc_rsp_valid_o;
    logic                acc_rsp_ready_i;
    dma_pkg::burst_req_t burst_req_o;
    logic                burst_valid_o;
    logic                burst_ready_i;
    logic                burst_done_i;
    logic                busy_o;

    stim_t               stim_q[$];
    dma_pkg::acc_rsp_t   exp_rsp_q[$];
    dma_pkg::burst_req_t exp_burst_q[$];
    int unsigned         done_due_q[$];
    logic [47:0]         stg_src;
    logic [47:0]         stg_dst;
    logic [31:0]         stg_src_str;
    logic [31:0]         stg_dst_str;
    logic [31:0]         stg_rep;
    logic [31:0]         rng_state;
    logic                burst_hold;
    logic                rsp_hold;
    int unsigned         cycle;
    int unsigned         limit;
    int unsigned         burst_cnt;

    dma_inst_frontend #(
        .REQ_FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .acc_req_i       (acc_req_i),
        .acc_req_valid_i (acc_req_valid_i),
        .acc_req_ready_o (acc_req_ready_o),
        .acc_rsp_o       (acc_rsp_o),
        .acc_rsp_valid_o (acc_rsp_valid_o),
        .acc_rsp_ready_i (acc_rsp_ready_i),
        .burst_req_o     (burst_req_o),
        .burst_valid_o   (burst_valid_o),
        .burst_ready_i   (burst_ready_i),
        .burst_done_i    (burst_done_i),
        .busy_o          (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_rsp(input string name, input dma_pkg::acc_rsp_t got,
                             input dma_pkg::acc_rsp_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_burst(input string name, input dma_pkg::burst_req_t got,
                               input dma_pkg::burst_req_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_stop($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        logic [3:0]  ctl;
        logic [4:0]  tag;
        logic [6:0]  funct;
        logic [1:0]  cfg;
        logic [63:0] arga;
        logic [63:0] argb;
        logic [63:0] rsp_data;
        fd = $fopen("dma_stim.txt", "r");
        if (fd == 0) begin
            fail_stop("cannot open the stim file dma_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h",
                                ctl, tag, funct, cfg, arga, argb, rsp_data);
                    if (n == 7) begin
                        stim_q.push_back({ctl, tag, funct, cfg, arga, argb, rsp_data});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // staged register model and expected bursts of an accepted instruction
    task automatic model_accept(input stim_t s);
        dma_pkg::acc_rsp_t   r;
        dma_pkg::burst_req_t b;
        logic                twod;
        int unsigned         n;
        int unsigned         k;
        r.tag   = s.tag;
        r.data  = s.rsp_data;
        r.error = 1'b0;
        case (s.funct)
            dma_pkg::DMSRC: stg_src = {s.argb[15:0], s.arga[31:0]};
            dma_pkg::DMDST: stg_dst = {s.argb[15:0], s.arga[31:0]};
            dma_pkg::DMSTR: begin
                stg_src_str = s.arga[31:0];
                stg_dst_str = s.argb[31:0];
            end
            dma_pkg::DMREP: stg_rep = s.arga[31:0];
            dma_pkg::DMCPYI, dma_pkg::DMCPY: begin
                twod = (s.funct == dma_pkg::DMCPYI) ? s.cfg[1] : s.argb[1];
                n    = (twod && stg_rep != 0) ? stg_rep : 1;
                for (k = 0; k < n; k++) begin
                    b.src_addr = stg_src + 48'(k) * 48'(stg_src_str);
                    b.dst_addr = stg_dst + 48'(k) * 48'(stg_dst_str);
                    b.length   = s.arga[47:0];
                    exp_burst_q.push_back(b);
                end
                exp_rsp_q.push_back(r);
            end
            dma_pkg::DMSTATI, dma_pkg::DMSTAT: exp_rsp_q.push_back(r);
            default: ;
        endcase
    endtask

    // release both holds, then wait until every burst, completion and response is through
    task automatic drain();
        burst_hold = 1'b0;
        rsp_hold   = 1'b0;
        do begin
            @(negedge clk_i);
        end while (exp_burst_q.size() != 0 || done_due_q.size() != 0 ||
                   exp_rsp_q.size() != 0 || busy_o);
        @(posedge clk_i);
        #2;
    endtask

    task automatic issue(input stim_t s);
        int unsigned waited;
        logic        accepted;
        if (s.ctl[0]) begin
            drain();
        end
        burst_hold = s.ctl[1];
        rsp_hold   = s.ctl[2];
        acc_req_i                = '0;
        acc_req_i.tag            = s.tag;
        acc_req_i.op.imm.funct7  = s.funct;
        acc_req_i.op.imm.cfg     = s.cfg;
        acc_req_i.op.enc.opcode  = dma_pkg::OPC_DMA;
        acc_req_i.arga           = s.arga;
        acc_req_i.argb           = s.argb;
        acc_req_valid_i          = 1'b1;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk_i);
            if (acc_req_ready_o) begin
                accepted = 1'b1;
            end else begin
                waited++;
                if (rsp_hold && waited == HOLD_CYCLES) begin
                    if (!s.ctl[3]) begin
                        fail_stop("instruction stalled although the response path had room");
                    end else begin
                        rsp_hold = 1'b0;
                    end
                end
            end
        end
        if (s.ctl[3] && waited < HOLD_CYCLES) begin
            fail_stop("instruction accepted while the response path was full");
        end else begin
            model_accept(s);
            @(posedge clk_i);
            #2;
            acc_req_valid_i = 1'b0;
        end
    endtask

    // ------------------------------
    // backend model and timeout
    // ------------------------------
    initial begin : proc_backend
        logic hold_b;
        logic hold_r;
        burst_ready_i   = 1'b0;
        acc_rsp_ready_i = 1'b0;
        burst_done_i    = 1'b0;
        rng_state       = 32'h25e0_692a;
        cycle           = 0;
        forever begin
            @(posedge clk_i);
            cycle++;
            hold_b = burst_hold;
            hold_r = rsp_hold;
            if (cycle > limit) begin
                fail_stop($sformatf("timeout, the run did not end within %0d cycles", limit));
            end else begin
                #2;
                rng_state       = xorshift(rng_state);
                burst_ready_i   = !hold_b && (rng_state[1:0] != 2'b00);
                acc_rsp_ready_i = !hold_r && (rng_state[3:2] != 2'b00);
                burst_done_i    = 1'b0;
                if (done_due_q.size() != 0 && done_due_q[0] <= cycle) begin
                    void'(done_due_q.pop_front());
                    burst_done_i = 1'b1;
                end
            end
        end
    end

    // outputs are stable at the falling edge, transfers land on the next rise
    always @(negedge clk_i) begin
        // a pending burst or an outstanding completion means a job is running
        if (rst_n_i && (burst_valid_o || done_due_q.size() != 0)) begin
            check_flag("busy_o", busy_o, 1'b1);
        end
        if (rst_n_i && acc_rsp_valid_o && acc_rsp_ready_i) begin
            if (exp_rsp_q.size() == 0) begin
                fail_stop("response arrived with no instruction waiting for one");
            end else begin
                check_rsp("acc_rsp_o", acc_rsp_o, exp_rsp_q.pop_front());
            end
        end
        if (rst_n_i && burst_valid_o && burst_ready_i) begin
            if (exp_burst_q.size() == 0) begin
                fail_stop("burst request issued with no copy job behind it");
            end else begin
                check_burst("burst_req_o", burst_req_o, exp_burst_q.pop_front());
                done_due_q.push_back(cycle + 2 + (burst_cnt % 3));
                burst_cnt++;
            end
        end
    end

    initial begin
        rst_n_i         = 1'b0;
        acc_req_i       = '0;
        acc_req_valid_i = 1'b0;
        burst_hold      = 1'b0;
        rsp_hold        = 1'b0;
        burst_cnt       = 0;
        stg_src         = '0;
        stg_dst         = '0;
        stg_src_str     = '0;
        stg_dst_str     = '0;
        stg_rep         = '0;
        load_stim();
        limit = 200 * stim_q.size();
        repeat (10) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        foreach (stim_q[i]) begin
            issue(stim_q[i]);
        end
        drain();
        if (u_dut.u_assert.fail_cnt == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_stop("concurrent assertions failed during the run");
        end
    end

endmodule

// File: dma_stim.txt
# ctl tag funct cfg arga argb rsp_data, all hex
# ctl bits: 0 drain first, 1 hold burst ready, 2 hold response ready, 3 expect stall
0 01 00 0 1000 12 0
0 02 01 0 8000 34 0
0 03 03 0 40 0 0
0 04 03 0 80 0 1
0 05 02 0 100 0 2
0 06 06 0 200 400 0
0 07 07 0 4 0 0
0 08 03 0 20 2 3
0 09 02 2 10 0 4
0 0a 07 0 9 0 0
0 0b 02 0 30 0 5
0 0c 03 0 30 0 6
0 0d 07 0 0 0 0
0 0e 03 0 8 2 7
1 0f 05 0 0 0 8
0 10 04 1 0 0 8
0 11 05 0 0 2 0
0 12 07 0 3 0 0
2 13 03 0 40 2 8
2 14 04 2 0 0 1
1 15 04 0 0 0 9
4 16 03 0 50 0 9
4 17 05 0 0 1 a
4 18 00 0 2000 0 0
c 19 03 0 60 0 a
0 1a 04 1 0 0 b
3 1b 03 0 10 0 b
2 1c 03 0 10 0 c
2 1d 03 0 10 0 d
2 1e 03 0 10 0 e
2 1f 05 0 0 3 1
1 00 05 0 0 0 f
0 01 05 0 0 1 f
0 02 04 3 0 0 0

// File: src.f
dma_pkg.sv
dma_tf_id_counter.sv
dma_rsp_spill.sv
dma_req_fifo.sv
dma_twod_splitter.sv
dma_inst_decoder.sv
dma_inst_frontend.sv
dma_inst_frontend_assert.sv
tb_dma_inst_frontend.sv

// File: Makefile
# Verilator build and run of the DMA instruction frontend testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_inst_frontend
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
